// File: tb.f
+incdir+hdl
hdl/socPkg.sv
hdl/resetSequencer.sv
hdl/swapByteCi.sv
hdl/delayCi.sv
hdl/profileControl.sv
hdl/profileCounters.sv
hdl/busArbiter.sv
hdl/singleCoreCi.sv
dv/clockGen.sv
dv/tbSingleCore.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line in the log
set -e

cd "$(dirname "$0")"

verilator --binary --timescale 1ns/10ps --top-module tbSingleCore -f tb.f -o simTb

./obj_dir/simTb | tee sim.log

grep -q 'All tests passed!' sim.log

// File: dv/tbSingleCore.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module tbSingleCore;

  localparam int ResetCycles    = 1 << (`RESET_COUNT_BITS - 1);
  localparam int SwapTests      = 200;
  localparam int DelayTests     = 20;
  localparam int MixTests       = 80;
  localparam int WatchdogCycles = 2 * (ResetCycles + SwapTests + MixTests * 16 +
                                       DelayTests * (5 * `CLOCKS_PER_US + 8) + 32);

  logic              s_systemClock;
  logic              s_pllLocked;
  logic              ciStart;
  socPkg::ciOpcode_t ciN;
  socPkg::ciWord_t   ciDataA;
  socPkg::ciWord_t   ciDataB;
  socPkg::grantVec_t busRequests;
  logic              endTransaction;
  logic              cpuStalled;
  logic              ciDone;
  socPkg::ciWord_t   ciResult;
  socPkg::grantVec_t busGrants;

  int                checkCount = 0;
  int                errorCount = 0;
  logic [15:0]       lfsrState  = 16'd34245;

  // Cycle model of the DUT, advanced at each falling edge
  int                               lockCycles  = 0;
  logic                             delayBusy   = 1'b0;
  int                               delayWait   = 0;
  logic                             arbBusy     = 1'b0;
  socPkg::grantVec_t                expGrant    = '0;
  logic [`NUM_PROFILE_COUNTERS-1:0] modelEnable = '0;
  logic [`NUM_PROFILE_COUNTERS-1:0] modelClear  = '0;
  socPkg::ciWord_t                  modelCount [`NUM_PROFILE_COUNTERS];

  clockGen clocks (.s_systemClock(s_systemClock), .s_pllLocked(s_pllLocked));

  singleCoreCi dut (.s_systemClock(s_systemClock), .s_pllLocked(s_pllLocked),
                    .ciStart(ciStart), .ciN(ciN), .ciDataA(ciDataA), .ciDataB(ciDataB),
                    .busRequests(busRequests), .endTransaction(endTransaction),
                    .cpuStalled(cpuStalled), .ciDone(ciDone), .ciResult(ciResult),
                    .busGrants(busGrants));

  function automatic logic [31:0] nextBits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
      bits = {bits[30:0], lfsrState[0]};
    end
    return bits;
  endfunction

  function automatic socPkg::ciWord_t swapRef(input socPkg::ciWord_t a, input socPkg::ciWord_t b);
    socPkg::ciWord_t r;
    for (int i = 0; i < 4; i++) begin
      if (b[0]) begin
        r[8*i +: 8] = a[8*(i^1) +: 8];  // Neighbour byte in the same half
      end else begin
        r[8*i +: 8] = a[8*(3-i) +: 8];
      end
    end
    return r;
  endfunction

  function automatic socPkg::grantVec_t grantRef(input socPkg::grantVec_t req);
    socPkg::grantVec_t g;
    g = '0;
    for (int i = `NUM_REQUESTERS - 1; i >= 0; i--) begin
      if (req[i] && g == '0) begin
        g[i] = 1'b1;
      end
    end
    return g;
  endfunction

  function automatic socPkg::ciWord_t counterRead(input logic [1:0] sel);
    if (sel == 2'd3) begin
      return '0;
    end
    return modelCount[sel];
  endfunction

  // Set, disable and clear fields, with no counter both set and disabled
  function automatic socPkg::ciWord_t controlWord();
    logic [2:0] setMask;
    logic [2:0] offMask;
    logic [2:0] clearMask;
    setMask   = 3'(nextBits(3));
    offMask   = 3'(nextBits(3)) & 3'(nextBits(3)) & ~setMask;
    clearMask = 3'(nextBits(3));
    return {21'b0, clearMask, 1'b0, offMask, 1'b0, setMask};
  endfunction

  task automatic checkWord(input string name, input socPkg::ciWord_t got,
                           input socPkg::ciWord_t exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkGrant(input string name, input socPkg::grantVec_t got,
                            input socPkg::grantVec_t exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic tick();
    @(posedge s_systemClock);
    cpuStalled <= nextBits(1) != 0;
  endtask

  task automatic issueCi(input socPkg::ciOpcode_t op, input socPkg::ciWord_t a,
                         input socPkg::ciWord_t b);
    ciStart <= 1'b1;
    ciN     <= op;
    ciDataA <= a;
    ciDataB <= b;
    tick();
    ciStart <= 1'b0;
  endtask

  task automatic waitDone(input int limit);
    int n;
    n = 0;
    @(negedge s_systemClock);
    while (!ciDone && n < limit) begin
      tick();
      @(negedge s_systemClock);
      n++;
    end
    if (!ciDone) begin
      errorCount++;
      $display("Delay unit gave no ciDone within %0d cycles", limit);
    end
    tick();
  endtask

  task automatic busTransaction();
    socPkg::grantVec_t req;
    int                n;
    req = socPkg::grantVec_t'(nextBits(4));
    if (req == '0) begin
      req = 4'b0001;
    end
    busRequests <= req;
    n = 0;
    tick();
    @(negedge s_systemClock);
    while (busGrants == '0 && n < 4) begin
      tick();
      @(negedge s_systemClock);
      n++;
    end
    if (busGrants == '0) begin
      errorCount++;
      $display("Arbiter gave no grant for requests %h", req);
    end
    tick();
    repeat (nextBits(2)) tick();
    endTransaction <= 1'b1;
    busRequests    <= socPkg::grantVec_t'(nextBits(4));  // Next winner, or an idle gap
    tick();
    endTransaction <= 1'b0;
  endtask

  always @(negedge s_systemClock) begin : compareModel
    logic                             inReset;
    logic                             delayWasBusy;
    logic                             expDone;
    socPkg::ciWord_t                  expResult;
    logic [`NUM_PROFILE_COUNTERS-1:0] countEvent;
    inReset      = (lockCycles < ResetCycles);
    delayWasBusy = delayBusy;
    expDone      = 1'b0;
    expResult    = '0;
    if (s_pllLocked && inReset) begin
      lockCycles++;
    end
    if (!inReset) begin
      if (delayBusy) begin
        delayWait--;
        if (delayWait == 0) begin
          expDone   = 1'b1;
          delayBusy = 1'b0;
        end
      end
      if (ciStart) begin
        case (ciN)
          socPkg::ciSwapByte: begin
            expDone   = 1'b1;
            expResult = expResult | swapRef(ciDataA, ciDataB);
          end
          socPkg::ciDelay: begin
            if (!delayWasBusy) begin
              delayBusy = 1'b1;
              delayWait = ciDataA * `CLOCKS_PER_US + 1;
            end
          end
          socPkg::ciProfile: begin
            expDone   = 1'b1;
            expResult = expResult | counterRead(ciDataA[1:0]);
          end
          default: ;
        endcase
      end
    end
    checkFlag("ciDone", ciDone, expDone);
    checkWord("ciResult", ciResult, expResult);
    checkGrant("busGrants", busGrants, expGrant);
    if (inReset) begin
      delayBusy   = 1'b0;
      arbBusy     = 1'b0;
      expGrant    = '0;
      modelEnable = '0;
      modelClear  = '0;
      for (int i = 0; i < `NUM_PROFILE_COUNTERS; i++) begin
        modelCount[i] = '0;
      end
    end else begin
      countEvent = {!arbBusy, cpuStalled, 1'b1};  // Bus idle, stall, every cycle
      for (int i = 0; i < `NUM_PROFILE_COUNTERS; i++) begin
        if (modelClear[i]) begin
          modelCount[i] = '0;
        end else if (modelEnable[i] && countEvent[i]) begin
          modelCount[i] = modelCount[i] + 1'b1;
        end
      end
      modelClear = '0;
      if (ciStart && ciN == socPkg::ciProfile) begin
        modelEnable = (modelEnable | ciDataB[2:0]) & ~ciDataB[6:4];
        modelClear  = ciDataB[10:8];
      end
      if (!arbBusy && busRequests != '0) begin
        arbBusy  = 1'b1;
        expGrant = grantRef(busRequests);
      end else if (arbBusy && endTransaction) begin
        arbBusy  = 1'b0;
        expGrant = '0;
      end
    end
  end

  initial begin : stimulus
    int n;
    ciStart        <= 1'b0;
    ciN            <= socPkg::ciSwapByte;
    ciDataA        <= '0;
    ciDataB        <= '0;
    busRequests    <= '0;
    endTransaction <= 1'b0;
    cpuStalled     <= 1'b0;
    @(posedge s_pllLocked);
    // Held in reset for the first 16, the last one is answered
    for (int i = 0; i <= ResetCycles; i++) begin
      issueCi(socPkg::ciSwapByte, nextBits(32), nextBits(32));
    end
    repeat (SwapTests) begin
      issueCi(socPkg::ciSwapByte, nextBits(32), nextBits(32));
    end
    repeat (DelayTests) begin
      n = nextBits(3) % 6;
      issueCi(socPkg::ciDelay, n, '0);
      if (n > 0) begin
        tick();
        issueCi(socPkg::ciDelay, nextBits(3), '0);  // Lands while counting
      end
      waitDone(5 * `CLOCKS_PER_US + 4);
    end
    issueCi(socPkg::ciProfile, '0, 32'h0000_0707);
    repeat (MixTests) begin
      case (nextBits(2))
        0: issueCi(socPkg::ciProfile, '0, controlWord());
        1, 2: issueCi(socPkg::ciProfile, nextBits(2), '0);
        default: busTransaction();
      endcase
      repeat (nextBits(2)) tick();
    end
    for (int s = 0; s < 4; s++) begin
      issueCi(socPkg::ciProfile, s, '0);
    end
    repeat (4) tick();
    $display("Checks run %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge s_systemClock);
    $display("Run did not finish within %0d cycles", WatchdogCycles);
    $display("Checks run %0d, errors %0d", checkCount, errorCount);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: dv/clockGen.sv
`timescale 1ns/10ps

module clockGen (
  output logic s_systemClock,
  output logic s_pllLocked
);

  localparam int HalfPeriod = 5;  // 10 ns clock

  initial begin
    s_systemClock = 1'b0;
    forever #HalfPeriod s_systemClock = ~s_systemClock;
  end

  initial begin
    s_pllLocked <= 1'b0;
    repeat (4) @(posedge s_systemClock);
    s_pllLocked <= 1'b1;  // PLL reports lock
  end

endmodule

// File: hdl/singleCoreCi.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module singleCoreCi (
  input  logic              s_systemClock,
  input  logic              s_pllLocked,
  input  logic              ciStart,
  input  socPkg::ciOpcode_t ciN,
  input  socPkg::ciWord_t   ciDataA,
  input  socPkg::ciWord_t   ciDataB,
  input  socPkg::grantVec_t busRequests,
  input  logic              endTransaction,
  input  logic              cpuStalled,
  output logic              ciDone,
  output socPkg::ciWord_t   ciResult,
  output socPkg::grantVec_t busGrants
);

  logic                             unitReset;
  logic                             unitStart;
  logic                             swapDone, delayDone, profileDone;
  socPkg::ciWord_t                  swapResult, delayResult, profileResult;
  logic [`NUM_PROFILE_COUNTERS-1:0] counterEnable;
  logic [`NUM_PROFILE_COUNTERS-1:0] counterClear;
  logic                             busIdle;

  resetSequencer resetSeq (.s_systemClock(s_systemClock), .s_pllLocked(s_pllLocked),
                           .unitReset(unitReset));

  // No unit may answer while still in reset
  assign unitStart = ciStart & ~unitReset;

  swapByteCi swapByte (.ciStart(unitStart), .ciN(ciN), .ciDataA(ciDataA),
                       .ciDataB(ciDataB), .done(swapDone), .result(swapResult));

  delayCi delayMicro (.s_systemClock(s_systemClock), .unitReset(unitReset),
                      .ciStart(unitStart), .ciN(ciN), .ciDataA(ciDataA),
                      .done(delayDone), .result(delayResult));

  profileControl profCtrl (.s_systemClock(s_systemClock), .unitReset(unitReset),
                           .ciStart(unitStart), .ciN(ciN), .ciDataB(ciDataB),
                           .counterEnable(counterEnable), .counterClear(counterClear));

  profileCounters profCnt (.s_systemClock(s_systemClock), .unitReset(unitReset),
                           .ciStart(unitStart), .ciN(ciN), .ciDataA(ciDataA),
                           .counterEnable(counterEnable), .counterClear(counterClear),
                           .cpuStalled(cpuStalled), .busIdle(busIdle),
                           .done(profileDone), .result(profileResult));

  busArbiter arbiter (.s_systemClock(s_systemClock), .unitReset(unitReset),
                      .busRequests(busRequests), .endTransaction(endTransaction),
                      .busGrants(busGrants), .busIdle(busIdle));

  // Idle units hold done and result at zero
  assign ciDone   = swapDone | delayDone | profileDone;
  assign ciResult = swapResult | delayResult | profileResult;

endmodule

// File: hdl/busArbiter.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module busArbiter (
  input  logic              s_systemClock,
  input  logic              unitReset,
  input  socPkg::grantVec_t busRequests,
  input  logic              endTransaction,
  output socPkg::grantVec_t busGrants,
  output logic              busIdle
);

  socPkg::arbState_t state;
  socPkg::grantVec_t winner;

  // Ascending scan so the highest set bit ends up winning
  always_comb begin
    winner = '0;
    for (int i = 0; i < `NUM_REQUESTERS; i++) begin
      if (busRequests[i]) begin
        winner    = '0;
        winner[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (unitReset) begin
      state     <= socPkg::arbIdle;
      busGrants <= '0;
    end else begin
      case (state)
        socPkg::arbIdle: begin
          if (busRequests != '0) begin
            state     <= socPkg::arbGranted;
            busGrants <= winner;
          end
        end
        socPkg::arbGranted: begin
          if (endTransaction) begin
            state     <= socPkg::arbIdle;
            busGrants <= '0;  // Drops on the edge after the end strobe
          end
        end
        default: begin
          state     <= socPkg::arbIdle;
          busGrants <= '0;
        end
      endcase
    end
  end

  assign busIdle = (state == socPkg::arbIdle);

endmodule

// File: hdl/profileCounters.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module profileCounters (
  input  logic                             s_systemClock,
  input  logic                             unitReset,
  input  logic                             ciStart,
  input  socPkg::ciOpcode_t                ciN,
  input  socPkg::ciWord_t                  ciDataA,
  input  logic [`NUM_PROFILE_COUNTERS-1:0] counterEnable,
  input  logic [`NUM_PROFILE_COUNTERS-1:0] counterClear,
  input  logic                             cpuStalled,
  input  logic                             busIdle,
  output logic                             done,
  output socPkg::ciWord_t                  result
);

  socPkg::ciWord_t                  counters [`NUM_PROFILE_COUNTERS];
  logic [`NUM_PROFILE_COUNTERS-1:0] countEvent;
  logic                             readStart;
  socPkg::profileSel_t              readSel;

  // Indexed by profileSel_t
  assign countEvent = {busIdle, cpuStalled, 1'b1};

  always_ff @(posedge s_systemClock) begin
    for (int i = 0; i < `NUM_PROFILE_COUNTERS; i++) begin
      if (unitReset || counterClear[i]) begin
        counters[i] <= '0;
      end else if (counterEnable[i] && countEvent[i]) begin
        counters[i] <= counters[i] + 1'b1;
      end
    end
  end

  assign readStart = ciStart && (ciN == socPkg::ciProfile);
  assign readSel   = socPkg::profileSel_t'(ciDataA[1:0]);
  assign done      = readStart;

  // Reads the value from before the edge
  always_comb begin
    result = '0;
    if (readStart) begin
      case (readSel)
        socPkg::profCycles:  result = counters[socPkg::profCycles];
        socPkg::profStall:   result = counters[socPkg::profStall];
        socPkg::profBusIdle: result = counters[socPkg::profBusIdle];
        default:             result = '0;  // Unused selector
      endcase
    end
  end

endmodule

// File: hdl/profileControl.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module profileControl (
  input  logic                             s_systemClock,
  input  logic                             unitReset,
  input  logic                             ciStart,
  input  socPkg::ciOpcode_t                ciN,
  input  socPkg::ciWord_t                  ciDataB,
  output logic [`NUM_PROFILE_COUNTERS-1:0] counterEnable,
  output logic [`NUM_PROFILE_COUNTERS-1:0] counterClear
);

  logic                             writeStart;
  logic [`NUM_PROFILE_COUNTERS-1:0] setMask;
  logic [`NUM_PROFILE_COUNTERS-1:0] resetMask;
  logic [`NUM_PROFILE_COUNTERS-1:0] clearMask;

  assign writeStart = ciStart && (ciN == socPkg::ciProfile);
  assign setMask    = ciDataB[0 +: `NUM_PROFILE_COUNTERS];
  assign resetMask  = ciDataB[4 +: `NUM_PROFILE_COUNTERS];
  assign clearMask  = ciDataB[8 +: `NUM_PROFILE_COUNTERS];

  always_ff @(posedge s_systemClock) begin
    if (unitReset) begin
      counterEnable <= '0;
      counterClear  <= '0;
    end else begin
      counterClear <= writeStart ? clearMask : '0;  // Single-cycle pulse
      if (writeStart) begin
        counterEnable <= (counterEnable | setMask) & ~resetMask;  // Disable wins
      end
    end
  end

endmodule

// File: hdl/delayCi.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module delayCi (
  input  logic              s_systemClock,
  input  logic              unitReset,
  input  logic              ciStart,
  input  socPkg::ciOpcode_t ciN,
  input  socPkg::ciWord_t   ciDataA,
  output logic              done,
  output socPkg::ciWord_t   result
);

  localparam int DividerBits = $clog2(`CLOCKS_PER_US);

  socPkg::delayState_t    state;
  socPkg::ciWord_t        usRemaining;
  logic [DividerBits-1:0] tickDivider;
  logic                   tickWrap;
  logic                   startDelay;

  assign startDelay = ciStart && (ciN == socPkg::ciDelay);
  assign tickWrap   = (tickDivider == DividerBits'(`CLOCKS_PER_US - 1));
  assign done       = (state == socPkg::delayCounting) && (usRemaining == '0);
  assign result     = '0;

  always_ff @(posedge s_systemClock) begin
    if (unitReset) begin
      state <= socPkg::delayIdle;
    end else begin
      case (state)
        socPkg::delayIdle: begin
          if (startDelay) begin
            state <= socPkg::delayCounting;
          end
        end
        socPkg::delayCounting: begin
          if (done) begin
            state <= socPkg::delayIdle;  // Starts meanwhile are dropped
          end
        end
        default: state <= socPkg::delayIdle;
      endcase
    end
  end

  // Idle keeps reloading, so the start edge captures the operand
  always_ff @(posedge s_systemClock) begin
    if (state == socPkg::delayIdle) begin
      usRemaining <= ciDataA;
      tickDivider <= '0;
    end else if (tickWrap) begin
      usRemaining <= usRemaining - 1'b1;
      tickDivider <= '0;
    end else begin
      tickDivider <= tickDivider + 1'b1;
    end
  end

endmodule

// File: hdl/swapByteCi.sv
`timescale 1ns/10ps

module swapByteCi (
  input  logic              ciStart,
  input  socPkg::ciOpcode_t ciN,
  input  socPkg::ciWord_t   ciDataA,
  input  socPkg::ciWord_t   ciDataB,
  output logic              done,
  output socPkg::ciWord_t   result
);

  socPkg::ciWord_t swapped;

  always_comb begin
    if (ciDataB[0]) begin
      swapped = {ciDataA[23:16], ciDataA[31:24], ciDataA[7:0], ciDataA[15:8]};  // Per half
    end else begin
      swapped = {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};  // Full word
    end
  end

  assign done   = ciStart && (ciN == socPkg::ciSwapByte);
  assign result = done ? swapped : '0;

endmodule

// File: hdl/resetSequencer.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic unitReset
);

  logic [`RESET_COUNT_BITS-1:0] resetCount;

  // Counts up after lock and parks once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[`RESET_COUNT_BITS-1]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign unitReset = ~resetCount[`RESET_COUNT_BITS-1];

endmodule

// File: hdl/socPkg.sv
`include "soc_consts.svh"

package socPkg;

  typedef logic [`CI_WIDTH-1:0] ciWord_t;

  typedef enum logic [`CI_OPCODE_WIDTH-1:0] {
    ciSwapByte = `CI_SWAP_BYTE,
    ciDelay    = `CI_DELAY,
    ciProfile  = `CI_PROFILE
  } ciOpcode_t;

  // Bit 3 dcache, 2 icache, 1 video, 0 camera
  typedef logic [`NUM_REQUESTERS-1:0] grantVec_t;

  typedef enum logic {arbIdle, arbGranted} arbState_t;

  typedef enum logic {delayIdle, delayCounting} delayState_t;

  typedef enum logic [1:0] {
    profCycles,
    profStall,
    profBusIdle
  } profileSel_t;

endpackage

// File: hdl/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Custom-instruction port
`define CI_WIDTH             32
`define CI_OPCODE_WIDTH      8

// Custom-instruction numbers
`define CI_SWAP_BYTE         1
`define CI_DELAY             6
`define CI_PROFILE           11

`define RESET_COUNT_BITS     5   // Top bit sets 16 cycles after lock
`define CLOCKS_PER_US        8

`define NUM_REQUESTERS       4
`define NUM_PROFILE_COUNTERS 3

`endif
